// ==== common/cdc_fifo_params.svh ====
// Dual-clock FIFO default configuration
// Depth, data word width and the number of flops in each
// Gray-count synchronizer

`ifndef CDC_FIFO_PARAMS_SVH
`define CDC_FIFO_PARAMS_SVH

// Number of entries, at least 2
`define CDC_FIFO_DEPTH 8

// Width of one data word
`define CDC_FIFO_DATA_WIDTH 16

// Flops per synchronizer chain, at least 2
`define CDC_FIFO_SYNC_STAGES 2

`endif

// ==== common/cdc_fifo_pkg.sv ====
// Dual-clock FIFO shared types
// Count, address and data types plus the Gray code conversions
// used by both flag managers

`include "cdc_fifo_params.svh"

package cdc_fifo_pkg;

  localparam int CountWidth = $clog2(`CDC_FIFO_DEPTH + 1);
  localparam int AddrWidth = $clog2(`CDC_FIFO_DEPTH);

  typedef logic [CountWidth-1:0] count_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [`CDC_FIFO_DATA_WIDTH-1:0] data_t;

  function automatic count_t bin2gray(count_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at or above it
  function automatic count_t gray2bin(count_t gray);
    count_t bin;
    bin[CountWidth-1] = gray[CountWidth-1];
    for (int i = CountWidth - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== common/cdc_count_if.sv ====
// Count exchange between the FIFO flag managers
// Carries each side's registered Gray count and its reset-active
// flag into the other clock domain

`timescale 1ns/1ps

interface cdc_count_if;

  // Driven in the push clock domain
  cdc_fifo_pkg::count_t push_count_gray;
  logic push_reset_active;

  // Driven in the pop clock domain
  cdc_fifo_pkg::count_t pop_count_gray;
  logic pop_reset_active;

  // Receiving side samples these only through its synchronizer flops
  modport push_side (
    output push_count_gray,
    output push_reset_active,
    input pop_count_gray,
    input pop_reset_active
  );

  modport pop_side (
    input push_count_gray,
    input push_reset_active,
    output pop_count_gray,
    output pop_reset_active
  );

endinterface

// ==== hw/cdc_fifo_ram.sv ====
// Dual-clock FIFO storage array
// Written on the push clock at the push side's write pointer and
// read without a clock at the pop side's read pointer. The flag
// managers keep the two pointers apart so a slot is never read
// while it is being written.

`timescale 1ns/1ps

`include "cdc_fifo_params.svh"

module cdc_fifo_ram #(
  parameter int Depth = `CDC_FIFO_DEPTH,
  parameter int DataWidth = `CDC_FIFO_DATA_WIDTH
) (
  input  logic                 push_clk,
  input  logic                 wr_en,
  input  cdc_fifo_pkg::addr_t  wr_addr,
  input  cdc_fifo_pkg::data_t  wr_data,
  input  cdc_fifo_pkg::addr_t  rd_addr,
  output cdc_fifo_pkg::data_t  rd_data
);

  logic [DataWidth-1:0] mem [Depth];

  // Payload storage only, contents are undefined until written
  always_ff @(posedge push_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Word at the head of the FIFO goes straight to the pop port
  assign rd_data = mem[rd_addr];

endmodule

// ==== hw/flag_mgr/cdc_fifo_push_flag_mgr.sv ====
// Dual-clock FIFO push flag manager
// Counts push beats, publishes the count in Gray code, brings the
// pop count over through a synchronizer and derives occupancy and
// full. Also drives the storage array write port.

`timescale 1ns/1ps

`include "cdc_fifo_params.svh"

module cdc_fifo_push_flag_mgr #(
  parameter int Depth = `CDC_FIFO_DEPTH
) (
  input  logic                  push_clk,
  input  logic                  push_rst,
  input  logic                  push_valid,
  output logic                  push_ready,
  input  cdc_fifo_pkg::data_t   push_data,
  output cdc_fifo_pkg::count_t  push_items,
  output logic                  full,
  output logic                  wr_en,
  output cdc_fifo_pkg::addr_t   wr_addr,
  output cdc_fifo_pkg::data_t   wr_data,
  cdc_count_if.push_side        cnt
);

  localparam int CountWidth = $bits(cdc_fifo_pkg::count_t);
  localparam int SyncStages = `CDC_FIFO_SYNC_STAGES;
  localparam logic [CountWidth:0] WrapOffset = 1 << CountWidth;

  cdc_fifo_pkg::count_t push_count;
  cdc_fifo_pkg::count_t push_count_next;
  cdc_fifo_pkg::count_t pop_count;
  logic [SyncStages-1:0][CountWidth-1:0] pop_gray_sync;
  logic [SyncStages-1:0] pop_active_sync;
  logic reset_active;
  logic [CountWidth:0] push_count_ext;
  logic [CountWidth:0] pop_count_ext;
  logic [CountWidth:0] items_ext;

  // Write port follows the beat directly
  assign wr_en = push_valid && push_ready;
  assign wr_addr = cdc_fifo_pkg::addr_t'(push_count);
  assign wr_data = push_data;

  // Count wraps through the full counter range
  assign push_count_next = push_count + cdc_fifo_pkg::count_t'(wr_en);

  always_ff @(posedge push_clk or posedge push_rst) begin
    if (push_rst) begin
      push_count <= '0;
      cnt.push_count_gray <= '0;
    end else begin
      push_count <= push_count_next;
      cnt.push_count_gray <= cdc_fifo_pkg::bin2gray(push_count_next);
    end
  end

  // Flag rises with reset and drops one cycle after release
  always_ff @(posedge push_clk or posedge push_rst) begin
    if (push_rst) begin
      reset_active <= 1'b1;
    end else begin
      reset_active <= 1'b0;
    end
  end

  assign cnt.push_reset_active = reset_active;

  // Assume the pop side is still in reset until told otherwise
  always_ff @(posedge push_clk or posedge push_rst) begin
    if (push_rst) begin
      pop_gray_sync <= '0;
      pop_active_sync <= '1;
    end else begin
      pop_gray_sync <= {pop_gray_sync[SyncStages-2:0], cnt.pop_count_gray};
      pop_active_sync <= {pop_active_sync[SyncStages-2:0], cnt.pop_reset_active};
    end
  end

  assign pop_count = cdc_fifo_pkg::gray2bin(pop_gray_sync[SyncStages-1]);

  // Occupancy as a wrap-aware difference of the two counts
  assign push_count_ext = {1'b0, push_count};
  assign pop_count_ext = {1'b0, pop_count};
  assign items_ext = (push_count_ext >= pop_count_ext) ?
      (push_count_ext - pop_count_ext) :
      (push_count_ext + WrapOffset - pop_count_ext);

  assign push_items = items_ext[CountWidth-1:0];
  assign full = (push_items == cdc_fifo_pkg::count_t'(Depth));

  // No pushes until both sides are out of reset
  assign push_ready = !full && !reset_active && !pop_active_sync[SyncStages-1];

endmodule

// ==== hw/flag_mgr/cdc_fifo_pop_flag_mgr.sv ====
// Dual-clock FIFO pop flag manager
// Counts pop beats, brings the push count over through a
// synchronizer and derives occupancy and empty. While the push side
// is in reset the last push count seen before it is held.

`timescale 1ns/1ps

`include "cdc_fifo_params.svh"

module cdc_fifo_pop_flag_mgr #(
  parameter int Depth = `CDC_FIFO_DEPTH
) (
  input  logic                  pop_clk,
  input  logic                  pop_rst,
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output cdc_fifo_pkg::count_t  pop_items,
  output logic                  empty,
  output cdc_fifo_pkg::addr_t   rd_addr,
  cdc_count_if.pop_side         cnt
);

  localparam int CountWidth = $bits(cdc_fifo_pkg::count_t);
  localparam int SyncStages = `CDC_FIFO_SYNC_STAGES;
  localparam logic [CountWidth:0] WrapOffset = 1 << CountWidth;

  logic pop_beat;
  logic reset_active;
  logic push_active;
  cdc_fifo_pkg::count_t pop_count;
  cdc_fifo_pkg::count_t pop_count_next;
  cdc_fifo_pkg::count_t pop_gray_stage;
  cdc_fifo_pkg::count_t push_count;
  cdc_fifo_pkg::count_t push_count_saved;
  cdc_fifo_pkg::count_t push_count_visible;
  logic [SyncStages-1:0][CountWidth-1:0] push_gray_sync;
  logic [SyncStages-1:0] push_active_sync;
  logic [CountWidth:0] pop_count_ext;
  logic [CountWidth:0] push_count_ext;
  logic [CountWidth:0] items_ext;

  assign pop_beat = pop_valid && pop_ready;
  assign pop_count_next = pop_count + cdc_fifo_pkg::count_t'(pop_beat);
  assign rd_addr = cdc_fifo_pkg::addr_t'(pop_count);

  always_ff @(posedge pop_clk or posedge pop_rst) begin
    if (pop_rst) begin
      pop_count <= '0;
    end else begin
      pop_count <= pop_count_next;
    end
  end

  always_ff @(posedge pop_clk or posedge pop_rst) begin
    if (pop_rst) begin
      reset_active <= 1'b1;
    end else begin
      reset_active <= 1'b0;
    end
  end

  assign cnt.pop_reset_active = reset_active;

  // Extra stage keeps a count change behind the reset-active flag
  always_ff @(posedge pop_clk or posedge pop_rst) begin
    if (pop_rst) begin
      pop_gray_stage <= '0;
      cnt.pop_count_gray <= '0;
    end else begin
      pop_gray_stage <= cdc_fifo_pkg::bin2gray(pop_count_next);
      cnt.pop_count_gray <= pop_gray_stage;
    end
  end

  always_ff @(posedge pop_clk or posedge pop_rst) begin
    if (pop_rst) begin
      push_gray_sync <= '0;
      push_active_sync <= '1;
    end else begin
      push_gray_sync <= {push_gray_sync[SyncStages-2:0], cnt.push_count_gray};
      push_active_sync <= {push_active_sync[SyncStages-2:0], cnt.push_reset_active};
    end
  end

  assign push_active = push_active_sync[SyncStages-1];
  assign push_count = cdc_fifo_pkg::gray2bin(push_gray_sync[SyncStages-1]);

  // Keep the last count from before the push side went into reset
  always_ff @(posedge pop_clk or posedge pop_rst) begin
    if (pop_rst) begin
      push_count_saved <= '0;
    end else if (!push_active) begin
      push_count_saved <= push_count;
    end
  end

  assign push_count_visible = push_active ? push_count_saved : push_count;

  assign pop_count_ext = {1'b0, pop_count};
  assign push_count_ext = {1'b0, push_count_visible};
  assign items_ext = (push_count_ext >= pop_count_ext) ?
      (push_count_ext - pop_count_ext) :
      (push_count_ext + WrapOffset - pop_count_ext);

  assign pop_items = items_ext[CountWidth-1:0];

  // Looks empty while either side is still leaving reset
  assign empty = (pop_items == '0) || reset_active || push_active;
  assign pop_valid = !empty;

endmodule

// ==== hw/cdc_fifo.sv ====
// Dual-clock FIFO top level
// Moves data words from the push clock domain to the pop clock
// domain with valid/ready streams on both sides. Each domain
// releases the shared reset through its own synchronizer.

`timescale 1ns/1ps

`include "cdc_fifo_params.svh"

module cdc_fifo #(
  parameter int Depth = `CDC_FIFO_DEPTH,
  parameter int DataWidth = `CDC_FIFO_DATA_WIDTH
) (
  input  logic                  push_clk,
  input  logic                  pop_clk,
  input  logic                  arst_n,
  input  logic                  push_valid,
  output logic                  push_ready,
  input  cdc_fifo_pkg::data_t   push_data,
  output cdc_fifo_pkg::count_t  push_items,
  output logic                  full,
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output cdc_fifo_pkg::data_t   pop_data,
  output cdc_fifo_pkg::count_t  pop_items,
  output logic                  empty
);

  localparam int SyncStages = `CDC_FIFO_SYNC_STAGES;

  logic [SyncStages-1:0] push_rst_sync;
  logic [SyncStages-1:0] pop_rst_sync;
  logic push_rst;
  logic pop_rst;
  logic wr_en;
  cdc_fifo_pkg::addr_t wr_addr;
  cdc_fifo_pkg::addr_t rd_addr;
  cdc_fifo_pkg::data_t wr_data;

  // Reset asserts at once and releases on the local clock
  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      push_rst_sync <= '1;
    end else begin
      push_rst_sync <= {push_rst_sync[SyncStages-2:0], 1'b0};
    end
  end

  always_ff @(posedge pop_clk or negedge arst_n) begin
    if (!arst_n) begin
      pop_rst_sync <= '1;
    end else begin
      pop_rst_sync <= {pop_rst_sync[SyncStages-2:0], 1'b0};
    end
  end

  assign push_rst = push_rst_sync[SyncStages-1];
  assign pop_rst = pop_rst_sync[SyncStages-1];

  cdc_count_if cnt ();

  cdc_fifo_push_flag_mgr #(
    .Depth(Depth)
  ) u_push_flag_mgr (
    .push_clk   (push_clk),
    .push_rst   (push_rst),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .push_items (push_items),
    .full       (full),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .cnt        (cnt.push_side)
  );

  cdc_fifo_pop_flag_mgr #(
    .Depth(Depth)
  ) u_pop_flag_mgr (
    .pop_clk   (pop_clk),
    .pop_rst   (pop_rst),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_items (pop_items),
    .empty     (empty),
    .rd_addr   (rd_addr),
    .cnt       (cnt.pop_side)
  );

  cdc_fifo_ram #(
    .Depth     (Depth),
    .DataWidth (DataWidth)
  ) u_ram (
    .push_clk (push_clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (pop_data)
  );

endmodule

// ==== tb/cdc_fifo_asserts.sv ====
// Dual-clock FIFO protocol checks
// Concurrent assertions on the reset state, the full and empty flags,
// the occupancy bounds and the pop-side hold rule. Bound into cdc_fifo.

`timescale 1ns/1ps

`include "cdc_fifo_params.svh"

module cdc_fifo_asserts #(
  parameter int Depth = `CDC_FIFO_DEPTH
) (
  input logic                  push_clk,
  input logic                  pop_clk,
  input logic                  arst_n,
  input logic                  push_ready,
  input cdc_fifo_pkg::count_t  push_items,
  input logic                  full,
  input logic                  pop_valid,
  input logic                  pop_ready,
  input cdc_fifo_pkg::data_t   pop_data,
  input cdc_fifo_pkg::count_t  pop_items,
  input logic                  empty
);

  int fail_count = 0;
  logic [3:0] push_up_cycles;
  logic [3:0] pop_up_cycles;
  logic push_settled;
  logic pop_settled;

  // Cycles since reset release, saturating once both sides are surely up
  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      push_up_cycles <= '0;
    end else if (!push_settled) begin
      push_up_cycles <= push_up_cycles + 4'd1;
    end
  end

  always_ff @(posedge pop_clk or negedge arst_n) begin
    if (!arst_n) begin
      pop_up_cycles <= '0;
    end else if (!pop_settled) begin
      pop_up_cycles <= pop_up_cycles + 4'd1;
    end
  end

  assign push_settled = &push_up_cycles;
  assign pop_settled = &pop_up_cycles;

  reset_push_state: assert property (@(posedge push_clk)
      (!arst_n || $rose(arst_n)) |-> (!push_ready && !full))
    else begin
      fail_count++;
      $error("CHECK FAILED t=%0t push_ready=%0b full=%0b in reset, expected 0 and 0",
             $time, $sampled(push_ready), $sampled(full));
    end

  reset_pop_state: assert property (@(posedge pop_clk)
      (!arst_n || $rose(arst_n)) |-> (!pop_valid && empty))
    else begin
      fail_count++;
      $error("CHECK FAILED t=%0t pop_valid=%0b empty=%0b in reset, expected 0 and 1",
             $time, $sampled(pop_valid), $sampled(empty));
    end

  ready_tracks_full: assert property (@(posedge push_clk) disable iff (!arst_n)
      push_settled |-> (push_ready == !full))
    else begin
      fail_count++;
      $error("CHECK FAILED t=%0t push_ready=%0b expected %0b",
             $time, $sampled(push_ready), !$sampled(full));
    end

  full_at_depth: assert property (@(posedge push_clk) disable iff (!arst_n)
      (full == (push_items == cdc_fifo_pkg::count_t'(Depth))) &&
      (push_items <= cdc_fifo_pkg::count_t'(Depth)))
    else begin
      fail_count++;
      $error("CHECK FAILED t=%0t full=%0b push_items=%0d with depth %0d",
             $time, $sampled(full), $sampled(push_items), Depth);
    end

  valid_tracks_empty: assert property (@(posedge pop_clk) disable iff (!arst_n)
      (pop_valid == !empty) && (pop_items <= cdc_fifo_pkg::count_t'(Depth)) &&
      (!pop_settled || (empty == (pop_items == '0))))
    else begin
      fail_count++;
      $error("CHECK FAILED t=%0t pop_valid=%0b empty=%0b pop_items=%0d",
             $time, $sampled(pop_valid), $sampled(empty), $sampled(pop_items));
    end

  // Stalled head word stays put until it is taken
  pop_hold: assert property (@(posedge pop_clk) disable iff (!arst_n)
      (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data)))
    else begin
      fail_count++;
      $error("CHECK FAILED t=%0t pop_data=%h expected %h while stalled",
             $time, $sampled(pop_data), $past(pop_data));
    end

endmodule

bind cdc_fifo cdc_fifo_asserts #(
  .Depth(Depth)
) u_asserts (
  .push_clk   (push_clk),
  .pop_clk    (pop_clk),
  .arst_n     (arst_n),
  .push_ready (push_ready),
  .push_items (push_items),
  .full       (full),
  .pop_valid  (pop_valid),
  .pop_ready  (pop_ready),
  .pop_data   (pop_data),
  .pop_items  (pop_items),
  .empty      (empty)
);

// ==== tb/cdc_fifo_tb.sv ====
// Dual-clock FIFO testbench
// Two offset clocks, random valid/ready traffic with a reference
// queue, a fill and drain pass and a reset in the middle of traffic

`timescale 1ns/1ps

`include "cdc_fifo_params.svh"

module cdc_fifo_tb;

  localparam int Depth = `CDC_FIFO_DEPTH;
  localparam int FillLimit = 64;
  localparam int DrainLimit = 64;
  localparam int RandomCycles = 1500;
  localparam int PreResetCycles = 300;
  localparam int PostResetCycles = 600;
  // Phases add up to roughly 2700 push cycles
  localparam int TimeoutCycles = 4000;

  logic push_clk = 1'b0;
  logic pop_clk = 1'b0;
  logic arst_n;
  logic push_valid;
  logic push_ready;
  cdc_fifo_pkg::data_t push_data;
  cdc_fifo_pkg::count_t push_items;
  logic full;
  logic pop_valid;
  logic pop_ready;
  cdc_fifo_pkg::data_t pop_data;
  cdc_fifo_pkg::count_t pop_items;
  logic empty;

  integer seed = 32'h9fe3abc4;
  int cycle_count = 0;
  int check_count = 0;
  int error_count = 0;
  int phase_count = 0;
  int push_total = 0;
  int pop_total = 0;
  // 0 holds pop_ready low, 1 keeps it high, 2 randomizes it
  int pop_mode = 0;
  logic push_beat_next = 1'b0;
  cdc_fifo_pkg::data_t ref_q[$];

  cdc_fifo uut (
    .push_clk   (push_clk),
    .pop_clk    (pop_clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .push_items (push_items),
    .full       (full),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data),
    .pop_items  (pop_items),
    .empty      (empty)
  );

  always #4 push_clk = ~push_clk;

  // Pop clock rises 3 ns after the push clock
  always begin
    #3;
    forever #4 pop_clk = ~pop_clk;
  end

  always @(posedge push_clk) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Run stopped at push cycle %0d before all phases finished", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int total_errors();
    return error_count + uut.u_asserts.fail_count;
  endfunction

  // One push cycle. Mode 0 idles, 1 always offers, 2 offers at random.
  // An offer that was not taken is held with the same word.
  task automatic push_step(input int mode);
    @(negedge push_clk);
    if (!(push_valid && !push_beat_next)) begin
      case (mode)
        1: push_valid = 1'b1;
        2: push_valid = ($random(seed) & 1) != 0;
        default: push_valid = 1'b0;
      endcase
      push_data = cdc_fifo_pkg::data_t'($random(seed));
    end
    // Ready is settled here and holds until the next rising edge
    push_beat_next = push_valid && push_ready;
    if (push_beat_next) begin
      ref_q.push_back(push_data);
      push_total++;
    end
  endtask

  // Called at a push falling edge, or before the first clock edge
  task automatic apply_reset();
    arst_n = 1'b0;
    push_valid = 1'b0;
    push_beat_next = 1'b0;
    ref_q.delete();
    repeat (16) @(negedge push_clk);
    arst_n = 1'b1;
  endtask

  task automatic drain_and_check(input string phase);
    pop_mode = 1;
    for (int i = 0; i < DrainLimit && !(empty && ref_q.size() == 0 && !push_valid); i++) begin
      push_step(0);
    end
    check_count += 2;
    assert (empty) else begin
      error_count++;
      $display("CHECK FAILED t=%0t empty=%0b expected 1 after %s", $time, empty, phase);
    end
    assert (ref_q.size() == 0) else begin
      error_count++;
      $display("Words still outstanding after %s: %0d", phase, ref_q.size());
    end
  endtask

  task automatic report_phase(input string name);
    phase_count++;
    $display("Phase %s done at cycle %0d: %0d pushed, %0d popped, %0d errors so far",
             name, cycle_count, push_total, pop_total, total_errors());
  endtask

  // Pop side drives ready and checks every word it takes
  always @(negedge pop_clk) begin : pop_driver
    cdc_fifo_pkg::data_t expected;
    case (pop_mode)
      0: pop_ready = 1'b0;
      1: pop_ready = 1'b1;
      default: pop_ready = ($random(seed) & 1) != 0;
    endcase
    if (pop_valid && pop_ready) begin
      pop_total++;
      check_count++;
      assert (ref_q.size() != 0) else begin
        error_count++;
        $display("A word was popped while no pushed word was outstanding");
      end
      if (ref_q.size() != 0) begin
        expected = ref_q.pop_front();
        assert (pop_data === expected) else begin
          error_count++;
          $display("CHECK FAILED t=%0t pop_data=%h expected %h", $time, pop_data, expected);
        end
      end
    end
  end

  initial begin
    arst_n = 1'b1;
    push_valid = 1'b0;
    push_data = '0;
    pop_ready = 1'b0;
    #1;
    apply_reset();

    // Fill with the pop side stalled
    pop_mode = 0;
    for (int i = 0; i < FillLimit && !full; i++) begin
      push_step(1);
    end
    check_count += 2;
    assert (full) else begin
      error_count++;
      $display("CHECK FAILED t=%0t full=%0b expected 1", $time, full);
    end
    assert (ref_q.size() == Depth) else begin
      error_count++;
      $display("Fill accepted %0d words instead of %0d", ref_q.size(), Depth);
    end
    report_phase("fill");

    drain_and_check("drain");
    report_phase("drain");

    pop_mode = 2;
    repeat (RandomCycles) push_step(2);
    report_phase("random traffic");

    repeat (PreResetCycles) push_step(2);
    apply_reset();
    repeat (PostResetCycles) push_step(2);
    drain_and_check("reset during traffic");
    report_phase("reset during traffic");

    $display("Summary: %0d phases, %0d pushed, %0d popped, %0d checks, %0d errors",
             phase_count, push_total, pop_total, check_count, total_errors());
    if (total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+common
common/cdc_fifo_pkg.sv
common/cdc_count_if.sv
hw/cdc_fifo_ram.sv
hw/flag_mgr/cdc_fifo_push_flag_mgr.sv
hw/flag_mgr/cdc_fifo_pop_flag_mgr.sv
hw/cdc_fifo.sv
tb/cdc_fifo_asserts.sv
tb/cdc_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: cdc_fifo

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cdc_fifo_pkg.sv
      - common/cdc_count_if.sv
      - hw/cdc_fifo_ram.sv
      - hw/flag_mgr/cdc_fifo_push_flag_mgr.sv
      - hw/flag_mgr/cdc_fifo_pop_flag_mgr.sv
      - hw/cdc_fifo.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/cdc_fifo_asserts.sv
      - tb/cdc_fifo_tb.sv
